// File: phold_defs.svh
`ifndef PHOLD_DEFS_SVH
`define PHOLD_DEFS_SVH

// event timestamp
`define PHOLD_TIME_WID 16

// logical-process id
`define PHOLD_NB_LPID 5

// processing cores served by the scheduler
`define PHOLD_NUM_CORE 4
`define PHOLD_NB_COREID 2

// event queue entries
`define PHOLD_Q_DEPTH 16

// width of each run counter
`define PHOLD_STAT_WID 32

// cancel set, process 0, time 0
`define PHOLD_NULL_MSG {1'b1, {(`PHOLD_NB_LPID + `PHOLD_TIME_WID){1'b0}}}

`endif

// File: phold_pkg.sv
`include "phold_defs.svh"

package phold_pkg;

   // event as seen by the cores
   typedef struct packed {
      logic                       cancel;
      logic [`PHOLD_NB_LPID-1:0]  lp_id;
      logic [`PHOLD_TIME_WID-1:0] ts;
   } event_msg_t;

   // same fields in queue order
   // a cleared not_cancel puts an anti-message ahead on equal time
   typedef struct packed {
      logic [`PHOLD_TIME_WID-1:0] ts;
      logic                       not_cancel;
      logic [`PHOLD_NB_LPID-1:0]  lp_id;
   } queue_key_t;

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_INIT,
      ST_READY,
      ST_RUNNING,
      ST_FINISHED
   } run_state_t;

   typedef struct packed {
      logic [`PHOLD_STAT_WID-1:0] total_cycles;
      logic [`PHOLD_STAT_WID-1:0] total_events;
      logic [`PHOLD_STAT_WID-1:0] total_antimsg;
   } run_stats_t;

endpackage

// File: phold_run_ctrl.sv
`timescale 1ns/1ps
`include "phold_defs.svh"

module phold_run_ctrl (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic [7:0]                 num_init_events,
   input  logic [`PHOLD_NB_LPID-1:0]  lp_mask,
   input  logic [`PHOLD_TIME_WID-1:0] sim_end,
   input  logic [`PHOLD_TIME_WID-1:0] gvt,
   input  logic                       q_full,
   output phold_pkg::run_state_t      state,
   output phold_pkg::event_msg_t      init_evt,
   output logic                       rtn_vld
);

   phold_pkg::run_state_t state_nxt;
   logic [8:0]            init_cnt;
   logic                  init_done;
   logic                  end_hit;

   // two cycles per initial event, inserts land on the even counts
   assign init_done = (init_cnt + 9'd1) >= {num_init_events, 1'b0};
   assign end_hit   = (state == phold_pkg::ST_RUNNING) && (gvt > sim_end);

   assign init_evt.cancel = 1'b0;
   assign init_evt.lp_id  = init_cnt[1 +: `PHOLD_NB_LPID] & lp_mask;
   assign init_evt.ts     = '0;

   always_comb begin
      state_nxt = state;
      case (state)
         phold_pkg::ST_IDLE:     state_nxt = phold_pkg::ST_INIT;
         phold_pkg::ST_INIT: begin
            if (init_done) begin
               state_nxt = phold_pkg::ST_READY;
            end
         end
         phold_pkg::ST_READY:    state_nxt = phold_pkg::ST_RUNNING;
         phold_pkg::ST_RUNNING: begin
            if (end_hit) begin
               state_nxt = phold_pkg::ST_FINISHED;
            end
         end
         phold_pkg::ST_FINISHED: state_nxt = phold_pkg::ST_IDLE;
         default:                state_nxt = phold_pkg::ST_IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state    <= phold_pkg::ST_IDLE;
         init_cnt <= '0;
         rtn_vld  <= 1'b0;
      end else begin
         state <= state_nxt;
         if (state == phold_pkg::ST_INIT) begin
            init_cnt <= init_cnt + 9'd1;
         end else begin
            init_cnt <= '0;
         end
         // end of run, or a full queue flagged to the host
         rtn_vld <= end_hit | q_full;
      end
   end

endmodule

// File: rr_arbiter.sv
`timescale 1ns/1ps

module rr_arbiter #(
   parameter int NR = 4,
   localparam int IW = (NR > 1) ? $clog2(NR) : 1
) (
   input  logic          clk,
   input  logic          rst_n,
   input  logic [NR-1:0] req,
   input  logic          advance,
   output logic [NR-1:0] gnt,
   output logic [IW-1:0] gnt_idx,
   output logic          gnt_vld
);

   logic [IW-1:0] ptr;
   logic [IW-1:0] ptr_nxt;
   logic [IW-1:0] pick_idx;
   logic          pick_vld;

   // once a grant is used, priority moves just past that requester
   always_comb begin
      if (!advance) begin
         ptr_nxt = ptr;
      end else if (gnt_idx == IW'(NR - 1)) begin
         ptr_nxt = '0;
      end else begin
         ptr_nxt = gnt_idx + 1'b1;
      end
   end

   always_comb begin
      int i;
      int pos;
      pick_vld = 1'b0;
      pick_idx = ptr_nxt;
      for (i = 0; i < NR; i++) begin
         pos = int'(ptr_nxt) + i;
         if (pos >= NR) begin
            pos = pos - NR;
         end
         if (!pick_vld && req[pos]) begin
            pick_vld = 1'b1;
            pick_idx = IW'(pos);
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ptr     <= '0;
         gnt     <= '0;
         gnt_idx <= '0;
         gnt_vld <= 1'b0;
      end else begin
         ptr     <= ptr_nxt;
         gnt     <= pick_vld ? (NR'(1) << pick_idx) : '0;
         gnt_idx <= pick_idx;
         gnt_vld <= pick_vld;
      end
   end

endmodule

// File: event_queue.sv
`timescale 1ns/1ps
`include "phold_defs.svh"

module event_queue #(
   parameter int DEPTH = 16
) (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  enq,
   input  logic                  deq,
   input  phold_pkg::queue_key_t in_key,
   output phold_pkg::queue_key_t head_key,
   output logic                  full,
   output logic                  empty
);

   localparam int CW = $clog2(DEPTH + 1);

   phold_pkg::queue_key_t      ent [DEPTH];
   logic [CW-1:0]              cnt;
   logic [DEPTH-1:0]           keep;
   logic [DEPTH-1:0]           ins_at;
   logic [`PHOLD_TIME_WID:0]   in_cmp;
   logic                       do_enq;
   logic                       do_deq;

   assign do_enq   = enq && !full;
   assign do_deq   = deq && !empty;
   assign full     = (cnt == CW'(DEPTH));
   assign empty    = (cnt == '0);
   assign head_key = ent[0];

   // sort on time and cancel only, process id does not take part
   assign in_cmp = {in_key.ts, in_key.not_cancel};

   // entries that stay put form a prefix, ties stay ahead of the new key
   always_comb begin
      int i;
      for (i = 0; i < DEPTH; i++) begin
         keep[i] = (CW'(i) < cnt) && ({ent[i].ts, ent[i].not_cancel} <= in_cmp);
      end
      ins_at[0] = !keep[0];
      for (i = 1; i < DEPTH; i++) begin
         ins_at[i] = keep[i-1] && !keep[i];
      end
   end

   always_ff @(posedge clk) begin
      if (do_enq) begin
         if (ins_at[0]) begin
            ent[0] <= in_key;
         end
         for (int i = 1; i < DEPTH; i++) begin
            if (ins_at[i]) begin
               ent[i] <= in_key;
            end else if (!keep[i]) begin
               ent[i] <= ent[i-1];
            end
         end
      end else if (do_deq) begin
         // head leaves, everything moves up one slot
         for (int i = 0; i < DEPTH - 1; i++) begin
            ent[i] <= ent[i+1];
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         cnt <= '0;
      end else if (do_enq) begin
         cnt <= cnt + 1'b1;
      end else if (do_deq) begin
         cnt <= cnt - 1'b1;
      end
   end

endmodule

// File: gvt_tracker.sv
`timescale 1ns/1ps
`include "phold_defs.svh"

module gvt_tracker (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        running,
   input  logic [`PHOLD_NUM_CORE-1:0]  dispatch_vld,
   input  logic [`PHOLD_TIME_WID-1:0]  dispatch_time,
   input  logic                        ack,
   input  logic [`PHOLD_NB_COREID-1:0] ack_idx,
   input  logic [`PHOLD_TIME_WID-1:0]  head_time,
   input  logic                        q_empty,
   output logic [`PHOLD_TIME_WID-1:0]  gvt
);

   logic [`PHOLD_NUM_CORE-1:0] busy;
   logic [`PHOLD_TIME_WID-1:0] held_ts [`PHOLD_NUM_CORE];
   logic [`PHOLD_TIME_WID-1:0] core_min;
   logic [`PHOLD_TIME_WID-1:0] queue_min;

   // timestamp each busy core is working on
   always_ff @(posedge clk) begin
      for (int k = 0; k < `PHOLD_NUM_CORE; k++) begin
         if (dispatch_vld[k]) begin
            held_ts[k] <= dispatch_time;
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         busy <= '0;
      end else begin
         for (int k = 0; k < `PHOLD_NUM_CORE; k++) begin
            if (dispatch_vld[k]) begin
               busy[k] <= 1'b1;
            end else if (ack && (ack_idx == `PHOLD_NB_COREID'(k))) begin
               busy[k] <= 1'b0;
            end
         end
      end
   end

   // all ones stands for nothing pending
   always_comb begin
      core_min = '1;
      for (int k = 0; k < `PHOLD_NUM_CORE; k++) begin
         if (busy[k] && (held_ts[k] < core_min)) begin
            core_min = held_ts[k];
         end
      end
   end

   assign queue_min = q_empty ? '1 : head_time;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         gvt <= '0;
      end else if (running) begin
         gvt <= (queue_min < core_min) ? queue_min : core_min;
      end
   end

endmodule

// File: phold_stats.sv
`timescale 1ns/1ps
`include "phold_defs.svh"

module phold_stats (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  running,
   input  logic                  deq,
   input  logic                  deq_cancel,
   output phold_pkg::run_stats_t stats
);

   logic [`PHOLD_STAT_WID-1:0] cycle_cnt;
   logic [`PHOLD_STAT_WID-1:0] event_cnt;
   logic [`PHOLD_STAT_WID-1:0] anti_cnt;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         cycle_cnt <= '0;
         event_cnt <= '0;
         anti_cnt  <= '0;
      end else begin
         if (running) begin
            cycle_cnt <= cycle_cnt + 1'b1;
         end
         // every dispatch counts, anti-messages also on their own
         if (deq) begin
            event_cnt <= event_cnt + 1'b1;
            if (deq_cancel) begin
               anti_cnt <= anti_cnt + 1'b1;
            end
         end
      end
   end

   assign stats.total_cycles  = cycle_cnt;
   assign stats.total_events  = event_cnt;
   assign stats.total_antimsg = anti_cnt;

endmodule

// File: phold_engine.sv
`timescale 1ns/1ps
`include "phold_defs.svh"

module phold_engine (
   input  logic                                       clk,
   input  logic                                       rst_n,
   input  logic [`PHOLD_TIME_WID-1:0]                 sim_end,
   input  logic [7:0]                                 num_init_events,
   input  logic [`PHOLD_NB_LPID-1:0]                  lp_mask,
   input  logic [`PHOLD_NUM_CORE-1:0]                 core_ready,
   input  logic [`PHOLD_NUM_CORE-1:0]                 core_evt_vld,
   input  phold_pkg::event_msg_t [`PHOLD_NUM_CORE-1:0] core_evt_msg,
   output logic [`PHOLD_NUM_CORE-1:0]                 dispatch_vld,
   output phold_pkg::event_msg_t                      dispatch_msg,
   output logic [`PHOLD_NUM_CORE-1:0]                 core_evt_ack,
   output logic [`PHOLD_TIME_WID-1:0]                 gvt,
   output logic                                       rtn_vld,
   output phold_pkg::run_stats_t                      stats
);

   phold_pkg::run_state_t      state;
   phold_pkg::event_msg_t      init_evt;
   phold_pkg::event_msg_t      new_evt;
   phold_pkg::queue_key_t      in_key;
   phold_pkg::queue_key_t      head_key;
   logic                       q_full;
   logic                       q_empty;
   logic                       in_init;
   logic                       in_run;
   logic                       busy;
   logic                       enq;
   logic                       deq;
   logic                       rcv_ack;
   logic                       q_enq;
   logic [`PHOLD_NUM_CORE-1:0] rcv_gnt;
   logic [`PHOLD_NB_COREID-1:0] rcv_idx;
   logic                       rcv_vld;
   logic [`PHOLD_NUM_CORE-1:0] send_gnt;
   logic                       send_vld;

   assign in_init = (state == phold_pkg::ST_INIT);
   assign in_run  = (state == phold_pkg::ST_RUNNING);

   // receiving has priority, at most one queue operation every other cycle
   assign enq = !busy && (in_init || (in_run && rcv_vld && !q_full));
   assign deq = !busy && in_run && !enq && !q_empty && send_vld;

   assign rcv_ack      = enq && in_run;
   assign core_evt_ack = rcv_ack ? rcv_gnt : '0;
   assign dispatch_vld = deq ? send_gnt : '0;

   assign new_evt = in_init ? init_evt : core_evt_msg[rcv_idx];

   // null messages are acknowledged and dropped
   assign q_enq = enq && (new_evt != `PHOLD_NULL_MSG);

   // event to queue order and back
   assign in_key.ts          = new_evt.ts;
   assign in_key.not_cancel  = ~new_evt.cancel;
   assign in_key.lp_id       = new_evt.lp_id;
   assign dispatch_msg.cancel = ~head_key.not_cancel;
   assign dispatch_msg.lp_id  = head_key.lp_id;
   assign dispatch_msg.ts     = head_key.ts;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         busy <= 1'b0;
      end else begin
         busy <= enq | deq;
      end
   end

   phold_run_ctrl u_run_ctrl (
      .clk             (clk),
      .rst_n           (rst_n),
      .num_init_events (num_init_events),
      .lp_mask         (lp_mask),
      .sim_end         (sim_end),
      .gvt             (gvt),
      .q_full          (q_full),
      .state           (state),
      .init_evt        (init_evt),
      .rtn_vld         (rtn_vld)
   );

   // new events coming back from the cores
   rr_arbiter #(.NR(`PHOLD_NUM_CORE)) u_rcv_arb (
      .clk     (clk),
      .rst_n   (rst_n),
      .req     (core_evt_vld),
      .advance (rcv_ack),
      .gnt     (rcv_gnt),
      .gnt_idx (rcv_idx),
      .gnt_vld (rcv_vld)
   );

   // idle cores waiting for work
   rr_arbiter #(.NR(`PHOLD_NUM_CORE)) u_send_arb (
      .clk     (clk),
      .rst_n   (rst_n),
      .req     (core_ready),
      .advance (deq),
      .gnt     (send_gnt),
      .gnt_idx (),
      .gnt_vld (send_vld)
   );

   event_queue #(.DEPTH(`PHOLD_Q_DEPTH)) u_event_queue (
      .clk      (clk),
      .rst_n    (rst_n),
      .enq      (q_enq),
      .deq      (deq),
      .in_key   (in_key),
      .head_key (head_key),
      .full     (q_full),
      .empty    (q_empty)
   );

   gvt_tracker u_gvt_tracker (
      .clk           (clk),
      .rst_n         (rst_n),
      .running       (in_run),
      .dispatch_vld  (dispatch_vld),
      .dispatch_time (dispatch_msg.ts),
      .ack           (rcv_ack),
      .ack_idx       (rcv_idx),
      .head_time     (head_key.ts),
      .q_empty       (q_empty),
      .gvt           (gvt)
   );

   phold_stats u_stats (
      .clk        (clk),
      .rst_n      (rst_n),
      .running    (in_run),
      .deq        (deq),
      .deq_cancel (dispatch_msg.cancel),
      .stats      (stats)
   );

endmodule

// File: phold_assertions.sv
`timescale 1ns/1ps
`include "phold_defs.svh"

module phold_assertions (
   input logic                       clk,
   input logic                       rst_n,
   input logic [`PHOLD_NUM_CORE-1:0] dispatch_vld,
   input logic [`PHOLD_NUM_CORE-1:0] core_evt_ack,
   input logic                       rtn_vld
);

   a_dispatch_onehot: assert property (@(posedge clk) disable iff (!rst_n)
      $onehot0(dispatch_vld))
      else $error("dispatch_vld has more than one bit set");

   // queue operations come at most every other cycle
   a_dispatch_spacing: assert property (@(posedge clk) disable iff (!rst_n)
      ((dispatch_vld != '0) || (core_evt_ack != '0)) |=> (dispatch_vld == '0))
      else $error("dispatch right after a dispatch or an acknowledge");

   a_quiet_in_reset: assert property (@(posedge clk)
      !rst_n |-> (!rtn_vld && (dispatch_vld == '0)))
      else $error("rtn_vld or dispatch_vld high during reset");

endmodule

bind phold_engine phold_assertions u_phold_assertions (
   .clk          (clk),
   .rst_n        (rst_n),
   .dispatch_vld (dispatch_vld),
   .core_evt_ack (core_evt_ack),
   .rtn_vld      (rtn_vld)
);

// File: tb_phold_engine.sv
`timescale 1ns/1ps
`include "phold_defs.svh"

module tb_phold_engine;

   localparam int NC       = `PHOLD_NUM_CORE;
   localparam int QD       = `PHOLD_Q_DEPTH;
   localparam int MAX_RESP = 64;

   logic                               clk;
   logic                               rst_n;
   logic [`PHOLD_TIME_WID-1:0]         sim_end;
   logic [7:0]                         num_init_events;
   logic [`PHOLD_NB_LPID-1:0]          lp_mask;
   logic [NC-1:0]                      core_ready;
   logic [NC-1:0]                      core_evt_vld;
   phold_pkg::event_msg_t [NC-1:0]     core_evt_msg;
   logic [NC-1:0]                      dispatch_vld;
   phold_pkg::event_msg_t              dispatch_msg;
   logic [NC-1:0]                      core_evt_ack;
   logic [`PHOLD_TIME_WID-1:0]         gvt;
   logic                               rtn_vld;
   phold_pkg::run_stats_t              stats;

   // one response per dispatch, in global dispatch order
   int                         resp_delay  [MAX_RESP];
   logic                       resp_null   [MAX_RESP];
   logic                       resp_cancel [MAX_RESP];
   logic [`PHOLD_NB_LPID-1:0]  resp_lp     [MAX_RESP];
   logic [`PHOLD_TIME_WID-1:0] resp_inc    [MAX_RESP];
   int                         num_resp;
   int                         exp_events;
   int                         exp_anti;

   // reference copy of what the queue should hold
   phold_pkg::event_msg_t      pend_msg [QD];
   int                         pend_seq [QD];
   int                         pend_cnt;
   int                         next_seq;

   // core model state
   int                         core_line [NC];
   int                         core_wait [NC];
   logic [NC-1:0]              core_working;
   phold_pkg::event_msg_t      core_job  [NC];

   int                         cyc;
   int                         disp_cnt;
   int                         anti_cnt;
   int                         timeout_cnt;
   int                         timeout_lim;
   logic [`PHOLD_TIME_WID-1:0] gvt_prev;
   logic                       started;

   phold_engine u_phold_engine (
      .clk             (clk),
      .rst_n           (rst_n),
      .sim_end         (sim_end),
      .num_init_events (num_init_events),
      .lp_mask         (lp_mask),
      .core_ready      (core_ready),
      .core_evt_vld    (core_evt_vld),
      .core_evt_msg    (core_evt_msg),
      .dispatch_vld    (dispatch_vld),
      .dispatch_msg    (dispatch_msg),
      .core_evt_ack    (core_evt_ack),
      .gvt             (gvt),
      .rtn_vld         (rtn_vld),
      .stats           (stats)
   );

   task automatic fail_run(string why);
      $display("%s", why);
      $display("Simulation FAILED");
      $fatal(1);
   endtask

   task automatic check_msg(string name, phold_pkg::event_msg_t got,
                            phold_pkg::event_msg_t exp);
      if (got !== exp) begin
         fail_run($sformatf("Fail %s: got %h, expected %h", name, got, exp));
      end
   endtask

   task automatic check_time(string name, logic [`PHOLD_TIME_WID-1:0] got,
                             logic [`PHOLD_TIME_WID-1:0] exp);
      if (got !== exp) begin
         fail_run($sformatf("Fail %s: got %h, expected %h", name, got, exp));
      end
   endtask

   task automatic check_stats(string name, phold_pkg::run_stats_t got,
                              phold_pkg::run_stats_t exp);
      if (got !== exp) begin
         fail_run($sformatf("Fail %s: got %h, expected %h", name, got, exp));
      end
   endtask

   task automatic check_flags(string name, logic [NC-1:0] got, logic [NC-1:0] exp);
      if (got !== exp) begin
         fail_run($sformatf("Fail %s: got %h, expected %h", name, got, exp));
      end
   endtask

   // time first, anti-message ahead on a tie, then arrival
   function automatic logic sorts_before(phold_pkg::event_msg_t a, int sa,
                                         phold_pkg::event_msg_t b, int sb);
      if (a.ts != b.ts) begin
         return a.ts < b.ts;
      end
      if (a.cancel != b.cancel) begin
         return a.cancel;
      end
      return sa < sb;
   endfunction

   task automatic add_pending(phold_pkg::event_msg_t msg);
      if (pend_cnt >= QD) begin
         fail_run("reference pending set overflowed the queue depth");
      end
      pend_msg[pend_cnt] = msg;
      pend_seq[pend_cnt] = next_seq;
      next_seq = next_seq + 1;
      pend_cnt = pend_cnt + 1;
   endtask

   task automatic take_earliest(output phold_pkg::event_msg_t msg);
      int best;
      if (pend_cnt == 0) begin
         fail_run("dispatch seen while no event was pending");
      end
      best = 0;
      for (int i = 1; i < pend_cnt; i++) begin
         if (sorts_before(pend_msg[i], pend_seq[i], pend_msg[best], pend_seq[best])) begin
            best = i;
         end
      end
      msg = pend_msg[best];
      for (int i = best; i < pend_cnt - 1; i++) begin
         pend_msg[i] = pend_msg[i+1];
         pend_seq[i] = pend_seq[i+1];
      end
      pend_cnt = pend_cnt - 1;
   endtask

   task automatic load_input();
      int    fd;
      int    code;
      string line;
      string rest;
      byte   tag;
      int    a;
      int    b;
      int    c;
      int    d;
      fd = $fopen("phold_engine_input.txt", "r");
      if (fd == 0) begin
         fail_run("cannot open phold_engine_input.txt");
      end
      while (!$feof(fd)) begin
         line = "";
         code = $fgets(line, fd);
         if (line.len() > 2) begin
            tag  = line.getc(0);
            rest = line.substr(2, line.len() - 1);
            if (tag == "C") begin
               code = $sscanf(rest, "%d %h %h", a, b, c);
               num_init_events = 8'(a);
               lp_mask         = `PHOLD_NB_LPID'(b);
               sim_end         = `PHOLD_TIME_WID'(c);
            end else if ((tag == "R") || (tag == "N")) begin
               if (num_resp >= MAX_RESP) begin
                  fail_run("too many response lines in the input file");
               end
               a = 0;
               b = 0;
               c = 0;
               d = 0;
               if (tag == "R") begin
                  code = $sscanf(rest, "%d %h %h %h", a, b, c, d);
               end else begin
                  code = $sscanf(rest, "%d", a);
               end
               resp_delay[num_resp]  = a;
               resp_null[num_resp]   = (tag == "N");
               resp_cancel[num_resp] = b[0];
               resp_lp[num_resp]     = `PHOLD_NB_LPID'(c);
               resp_inc[num_resp]    = `PHOLD_TIME_WID'(d);
               num_resp = num_resp + 1;
            end else if (tag == "E") begin
               code = $sscanf(rest, "%d %d", a, b);
               exp_events = a;
               exp_anti   = b;
            end
         end
      end
      $fclose(fd);
   endtask

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   initial begin
      phold_pkg::event_msg_t init_msg;
      rst_n           = 1'b0;
      sim_end         = '0;
      num_init_events = '0;
      lp_mask         = '0;
      core_ready      = '1;
      core_evt_vld    = '0;
      core_evt_msg    = '0;
      core_working    = '0;
      pend_cnt        = 0;
      next_seq        = 0;
      num_resp        = 0;
      exp_events      = 0;
      exp_anti        = 0;
      cyc             = 0;
      disp_cnt        = 0;
      anti_cnt        = 0;
      timeout_cnt     = 0;
      gvt_prev        = '0;
      started         = 1'b0;
      load_input();
      timeout_lim = 40 * num_resp + 200;
      if (int'(num_init_events) > QD) begin
         fail_run("more initial events than queue entries");
      end
      // the queue starts with the initial events in order
      for (int i = 0; i < int'(num_init_events); i++) begin
         init_msg.cancel = 1'b0;
         init_msg.lp_id  = `PHOLD_NB_LPID'(i) & lp_mask;
         init_msg.ts     = '0;
         add_pending(init_msg);
      end
      repeat (4) @(posedge clk);
      rst_n <= 1'b1;
   end

   always @(posedge clk) begin
      if (rst_n) begin
         timeout_cnt = timeout_cnt + 1;
         if (timeout_cnt > timeout_lim) begin
            fail_run($sformatf("no end-of-run pulse within %0d cycles", timeout_lim));
         end
      end
   end

   // core model and checks
   // outputs are sampled before the edge updates them
   always @(posedge clk) begin
      int                         k;
      logic [`PHOLD_TIME_WID-1:0] gvt_was;
      phold_pkg::event_msg_t      exp_msg;
      phold_pkg::event_msg_t      init_msg;
      phold_pkg::run_stats_t      exp_stats;
      if (rst_n) begin
         cyc = cyc + 1;
         if (!started) begin
            check_flags("core_evt_ack", core_evt_ack, '0);
            check_flags("rtn_vld", NC'(rtn_vld), '0);
            check_time("gvt", gvt, '0);
         end

         for (int i = 0; i < NC; i++) begin
            if (core_evt_ack[i]) begin
               if (!core_evt_vld[i]) begin
                  fail_run("acknowledge sent to a core with no event waiting");
               end
               if (pend_cnt >= QD) begin
                  fail_run("event acknowledged while the queue was full");
               end
               if (!resp_null[core_line[i]]) begin
                  add_pending(core_evt_msg[i]);
               end
               core_evt_vld[i] <= 1'b0;
               core_ready[i]   <= 1'b1;
            end
         end

         for (int i = 0; i < NC; i++) begin
            if (core_working[i]) begin
               if (core_wait[i] == 0) begin
                  core_working[i] = 1'b0;
                  core_evt_vld[i] <= 1'b1;
                  core_evt_msg[i] <= core_job[i];
               end else begin
                  core_wait[i] = core_wait[i] - 1;
               end
            end
         end

         if (dispatch_vld != '0) begin
            started = 1'b1;
            if (!$onehot(dispatch_vld)) begin
               fail_run("more than one dispatch_vld bit set");
            end
            k = 0;
            for (int i = 0; i < NC; i++) begin
               if (dispatch_vld[i]) begin
                  k = i;
               end
            end
            if (!core_ready[k]) begin
               fail_run("event dispatched to a core that was not ready");
            end
            if (disp_cnt >= num_resp) begin
               fail_run("more dispatches than response lines");
            end
            take_earliest(exp_msg);
            check_msg("dispatch_msg", dispatch_msg, exp_msg);
            if (disp_cnt < int'(num_init_events)) begin
               init_msg.cancel = 1'b0;
               init_msg.lp_id  = `PHOLD_NB_LPID'(disp_cnt) & lp_mask;
               init_msg.ts     = '0;
               check_msg("dispatch_msg", dispatch_msg, init_msg);
            end
            if (dispatch_msg.cancel) begin
               anti_cnt = anti_cnt + 1;
            end
            // null is cancel set, process 0, time 0
            if (resp_null[disp_cnt]) begin
               core_job[k].cancel = 1'b1;
               core_job[k].lp_id  = '0;
               core_job[k].ts     = '0;
            end else begin
               core_job[k].cancel = resp_cancel[disp_cnt];
               core_job[k].lp_id  = resp_lp[disp_cnt];
               core_job[k].ts     = dispatch_msg.ts + resp_inc[disp_cnt];
            end
            core_line[k]    = disp_cnt;
            core_wait[k]    = resp_delay[disp_cnt];
            core_working[k] = 1'b1;
            disp_cnt = disp_cnt + 1;
            core_ready[k] <= 1'b0;
         end

         gvt_was  = gvt_prev;
         gvt_prev = gvt;

         if (!rtn_vld && (gvt_was > sim_end)) begin
            fail_run("gvt passed sim_end without an end-of-run pulse");
         end

         if (rtn_vld) begin
            if (gvt_was <= sim_end) begin
               fail_run("rtn_vld pulsed before gvt passed sim_end");
            end
            // the pulse was raised in cycle cyc-1
            // running began 2 + 2*N cycles after release
            exp_stats.total_cycles  = 32'(cyc - 3 - 2 * int'(num_init_events));
            exp_stats.total_events  = 32'(exp_events);
            exp_stats.total_antimsg = 32'(exp_anti);
            check_stats("stats", stats, exp_stats);
            check_time("gvt", gvt, '1);
            if ((disp_cnt != exp_events) || (anti_cnt != exp_anti)) begin
               fail_run("dispatch counts seen on the bus differ from the expected line");
            end
            if ((disp_cnt == num_resp) && (pend_cnt == 0) && (core_working == '0)) begin
               $display("Simulation PASSED");
               $finish;
            end else begin
               fail_run("run ended with events still outstanding");
            end
         end
      end
   end

endmodule

// File: phold_engine_input.txt
# C num_init_events lp_mask(hex) sim_end(hex) | R delay cancel lp(hex) inc(hex)
# N delay for a null response | E expected_events expected_antimsg
C 10 07 7fff
R 3 0 04 0005
R 1 0 1a 0003
N 2
R 5 1 03 0005
R 2 0 11 0002
R 4 0 07 0001
R 1 1 0c 0003
N 3
R 6 0 02 0004
R 2 0 1f 0002
N 1
R 3 1 09 0001
N 4
R 2 0 05 0006
N 2
N 1
N 5
N 2
N 3
N 1
E 20 3

// File: phold_engine.f
+incdir+.
phold_pkg.sv
phold_run_ctrl.sv
rr_arbiter.sv
event_queue.sv
gvt_tracker.sv
phold_stats.sv
phold_engine.sv
phold_assertions.sv
tb_phold_engine.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := tb_phold_engine
FLIST     := phold_engine.f
VFLAGS    := --binary --timing --assert -j 0
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
SRCS      := $(filter-out +%,$(shell cat $(FLIST))) phold_defs.svh

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)
